// ==== verilog/sobelPkg.sv ====
`default_nettype none

package sobelPkg;

    typedef logic [7:0] pixelT;              // Camera pixel, unsigned gray level.
    typedef logic signed [15:0] gradientT;   // Signed sum of one Sobel gradient.
    typedef logic [15:0] thresholdT;         // Unsigned edge threshold.
    typedef logic [31:0] edgeWordT;          // Packed edge bits, first pixel in bit 31.

    localparam int WordBits = 32;            // Edge bits collected per output word.

    // Result of one lane for the pixel that is on the bus right now.
    typedef struct packed {
        logic     done;                      // This pixel closes the lane's window.
        gradientT gx;                        // Horizontal gradient of that window.
        gradientT gy;                        // Vertical gradient of that window.
    } laneResultT;

    // Horizontal kernel, indexed by row offset and then column offset.
    localparam int KernelX [3][3] = '{
        '{-1, 0, 1},                         // Top row.
        '{-2, 0, 2},                         // Middle row carries double weight.
        '{-1, 0, 1}                          // Bottom row.
    };

    // Vertical kernel in the same order.
    localparam int KernelY [3][3] = '{
        '{ 1,  2,  1},                       // Top row counts positive.
        '{ 0,  0,  0},                       // Middle row drops out.
        '{-1, -2, -1}                        // Bottom row counts negative.
    };

endpackage

`default_nettype wire

// ==== verilog/frameGeometryPkg.sv ====
`default_nettype none

package frameGeometryPkg;

    localparam int LineWidth = 64;                   // Longest line in pixels.
    localparam int SlotCount = (LineWidth + 2) / 3;  // Windows per lane and line, 22.

    typedef logic [$clog2(LineWidth)-1:0] columnT;   // Column index inside a line.
    typedef logic [$clog2(SlotCount)-1:0] slotT;     // Window slot inside a lane.

    // Modulo-3 phase of the row and column counters.
    typedef enum logic [1:0] {
        Phase0,
        Phase1,
        Phase2
    } phaseT;

    // Scan position that the sequencer hands to every lane and the packer.
    typedef struct packed {
        sobelPkg::pixelT pixel;              // Pixel data of this cycle.
        logic            strobe;             // Pixel is accepted at the coming edge.
        phaseT           columnPhase;        // Column modulo 3.
        phaseT           rowPhase;           // Row modulo 3.
        slotT            columnGroup;        // Column divided by 3.
        logic            windowComplete;     // Window lies fully inside the frame.
    } scanPosT;

endpackage

`default_nettype wire

// ==== verilog/scanSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module scanSequencer
    import sobelPkg::*, frameGeometryPkg::*;
(
    input  logic    camClock,
    input  logic    reset,
    input  logic    pixelValid,
    input  pixelT   pixel,
    input  logic    hsync,
    input  logic    vsync,
    output scanPosT scanPos
);

    phaseT      columnPhase;      // Column modulo 3.
    phaseT      rowPhase;         // Row modulo 3.
    slotT       columnGroup;      // Steps once every three pixels.
    columnT     column;           // Pixels accepted in the current line.
    logic [1:0] rowCount;         // Finished lines in this frame, stops at 2.
    logic       lineFull;         // LineWidth pixels were accepted in this line.
    logic       lineStarted;

    // Modulo-3 step of a phase counter.
    function automatic phaseT nextPhase(input phaseT phase);
        case (phase)
            Phase0:  return Phase1;
            Phase1:  return Phase2;
            default: return Phase0;
        endcase
    endfunction

    // An hsync without a single pixel before it does not end a line, so a
    // leading hsync right after vsync leaves the row numbering alone.
    assign lineStarted = (column != '0) || lineFull;

    always_ff @(posedge camClock) begin
        if (reset || vsync) begin
            columnPhase <= Phase0;                      // New frame starts at row 0, column 0.
            rowPhase    <= Phase0;
            columnGroup <= '0;
            column      <= '0;
            rowCount    <= '0;
            lineFull    <= 1'b0;
        end else if (hsync) begin
            columnPhase <= Phase0;                      // Next line starts at column 0.
            columnGroup <= '0;
            column      <= '0;
            lineFull    <= 1'b0;
            if (lineStarted) begin
                rowPhase <= nextPhase(rowPhase);        // Rows rotate through the lanes.
                if (rowCount != 2'd2) begin
                    rowCount <= rowCount + 2'd1;        // Saturates once two rows are past.
                end
            end
        end else if (pixelValid) begin
            column      <= column + columnT'(1);        // Wraps after the last column.
            columnPhase <= nextPhase(columnPhase);
            if (columnPhase == Phase2) begin
                columnGroup <= columnGroup + slotT'(1); // Three more columns done.
            end
            if (column == columnT'(LineWidth - 1)) begin
                lineFull <= 1'b1;                       // Only sync may follow now.
            end
        end
    end

    always_comb begin
        scanPos.pixel          = pixel;
        scanPos.strobe         = pixelValid;
        scanPos.columnPhase    = columnPhase;
        scanPos.rowPhase       = rowPhase;
        scanPos.columnGroup    = columnGroup;
        scanPos.windowComplete = (rowCount == 2'd2) && (column >= columnT'(2)); // Rows 0, 1 and columns 0, 1 give no edge.
    end

    // A line longer than LineWidth would overrun the lane slots.
    lineLengthCheck: assert property (@(posedge camClock) disable iff (reset)
        pixelValid |-> !lineFull);

    // Sync pulses sit in the gaps between pixels.
    syncGapCheck: assert property (@(posedge camClock) disable iff (reset)
        (hsync || vsync) |-> !pixelValid);

endmodule

`default_nettype wire

// ==== verilog/windowLane.sv ====
`timescale 1ns/10ps
`default_nettype none

module windowLane
    import sobelPkg::*, frameGeometryPkg::*;
#(
    parameter int RowOffset    = 0,  // Row phase of the top row of this lane's windows.
    parameter int ColumnOffset = 0   // Column phase of their left column.
) (
    input  logic       camClock,
    input  scanPosT    scanPos,
    output laneResultT laneResult
);

    gradientT   sumX [SlotCount];    // Running X sums, one per open window.
    gradientT   sumY [SlotCount];    // Running Y sums in the same slots.

    logic [1:0] rowPos;              // Row of the pixel inside this lane's window.
    logic [1:0] colPos;              // Column of the pixel inside the window.
    logic       borrow;              // Window began in the previous column group.
    logic       slotValid;           // Pixel belongs to a window inside the line.
    slotT       slot;
    logic       freshStart;
    gradientT   contribX;
    gradientT   contribY;
    gradientT   storedX;
    gradientT   storedY;
    gradientT   nextX;
    gradientT   nextY;

    always_comb begin
        rowPos = 2'((int'(scanPos.rowPhase) + 3 - RowOffset) % 3);       // Distance below the top row.
        colPos = 2'((int'(scanPos.columnPhase) + 3 - ColumnOffset) % 3); // Distance right of the left column.

        // The window's left column sits colPos columns back, which may be in
        // the group before the current one.
        borrow    = int'(scanPos.columnPhase) < ColumnOffset;
        slotValid = !(borrow && (scanPos.columnGroup == '0)); // Left of the first window otherwise.
        slot      = slotValid ? scanPos.columnGroup - slotT'(borrow) : '0;

        // Weighted pixel; the zero-extended pixel stays positive after the cast.
        contribX = gradientT'(KernelX[rowPos][colPos]) * gradientT'({1'b0, scanPos.pixel});
        contribY = gradientT'(KernelY[rowPos][colPos]) * gradientT'({1'b0, scanPos.pixel});

        storedX    = sumX[slot];
        storedY    = sumY[slot];
        freshStart = (rowPos == 2'd0) && (colPos == 2'd0); // Top-left corner opens a window.
        nextX      = freshStart ? contribX : storedX + contribX;
        nextY      = freshStart ? contribY : storedY + contribY;
    end

    always_ff @(posedge camClock) begin
        if (scanPos.strobe && slotValid) begin
            sumX[slot] <= nextX;     // A slot is reused three rows later.
            sumY[slot] <= nextY;
        end
    end

    // Bottom-right corner closes the window in this very cycle.
    always_comb begin
        laneResult.done = scanPos.strobe && (rowPos == 2'd2) && (colPos == 2'd2);
        laneResult.gx   = nextX;     // Garbage for windows outside the frame.
        laneResult.gy   = nextY;     // The packer masks those with windowComplete.
    end

    // The sequencer's column group must fit the slot storage of every lane.
    slotRangeCheck: assert property (@(posedge camClock)
        scanPos.strobe |-> (slot < slotT'(SlotCount)));

endmodule

`default_nettype wire

// ==== verilog/edgePacker.sv ====
`timescale 1ns/10ps
`default_nettype none

module edgePacker
    import sobelPkg::*, frameGeometryPkg::*;
(
    input  logic       camClock,
    input  logic       reset,
    input  logic       hsync,
    input  logic       vsync,
    input  scanPosT    scanPos,
    input  laneResultT laneResults [9],
    input  thresholdT  threshold,
    output logic       edgeWordValid,
    output edgeWordT   edgeWord
);

    logic [8:0]                  doneLanes;  // Done flags of all nine lanes.
    gradientT                    gx;         // Gradients of the finished window.
    gradientT                    gy;
    thresholdT                   absX;
    thresholdT                   absY;
    thresholdT                   magnitude;  // |gx| + |gy|, at most 2040.
    logic                        edgeBit;
    logic [$clog2(WordBits)-1:0] bitCount;   // Bits already in the word.

    always_comb begin
        gx = '0;
        gy = '0;
        for (int lane = 0; lane < 9; lane++) begin
            doneLanes[lane] = laneResults[lane].done;
            if (laneResults[lane].done) begin
                gx = gx | laneResults[lane].gx;  // Only one lane finishes per pixel.
                gy = gy | laneResults[lane].gy;
            end
        end
        absX      = thresholdT'(gx[15] ? -gx : gx);
        absY      = thresholdT'(gy[15] ? -gy : gy);
        magnitude = absX + absY;
        edgeBit   = scanPos.windowComplete && (magnitude > threshold); // Frame border gives 0.
    end

    always_ff @(posedge camClock) begin
        if (reset || hsync || vsync) begin
            bitCount      <= '0;     // A partly filled word is dropped.
            edgeWord      <= '0;
            edgeWordValid <= 1'b0;
        end else begin
            edgeWordValid <= scanPos.strobe && (bitCount == '1); // All ones is the last bit.
            if (scanPos.strobe) begin
                edgeWord <= {edgeWord[WordBits-2:0], edgeBit}; // First bit ends up in bit 31.
                bitCount <= bitCount + 1'b1;                   // Wraps into the next word.
            end
        end
    end

    // The nine lanes together must close exactly one window per pixel.
    oneLaneDoneCheck: assert property (@(posedge camClock) disable iff (reset)
        scanPos.strobe |-> $onehot(doneLanes));

endmodule

`default_nettype wire

// ==== verilog/sobelEdgeDetector.sv ====
`timescale 1ns/10ps
`default_nettype none

module sobelEdgeDetector
    import sobelPkg::*, frameGeometryPkg::*;
(
    input  logic      camClock,
    input  logic      reset,
    input  logic      pixelValid,
    input  logic      hsync,
    input  logic      vsync,
    input  pixelT     pixel,
    input  thresholdT threshold,
    output logic      edgeWordValid,
    output edgeWordT  edgeWord
);

    scanPosT    scanPos;           // Broadcast to all lanes and the packer.
    laneResultT laneResults [9];   // Lane i covers row offset i/3, column offset i%3.

    scanSequencer i_scanSequencer (
        .camClock   (camClock),
        .reset      (reset),
        .pixelValid (pixelValid),
        .pixel      (pixel),
        .hsync      (hsync),
        .vsync      (vsync),
        .scanPos    (scanPos)
    );

    // Nine lanes, one for each row and column phase of a window's top-left corner.
    for (genvar lane = 0; lane < 9; lane++) begin : laneGen
        windowLane #(
            .RowOffset    (lane / 3),
            .ColumnOffset (lane % 3)
        ) i_windowLane (
            .camClock   (camClock),
            .scanPos    (scanPos),
            .laneResult (laneResults[lane])
        );
    end

    edgePacker i_edgePacker (
        .camClock      (camClock),
        .reset         (reset),
        .hsync         (hsync),
        .vsync         (vsync),
        .scanPos       (scanPos),
        .laneResults   (laneResults),
        .threshold     (threshold),
        .edgeWordValid (edgeWordValid),
        .edgeWord      (edgeWord)
    );

endmodule

`default_nettype wire

// ==== testbench/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic camClock,
    output logic reset
);

    localparam int HalfPeriod  = 50;     // Half of the 100 ns camera clock period.
    localparam int ResetCycles = 4;      // Reset stays high for this many rising edges.

    initial begin
        camClock = 1'b0;
        forever #HalfPeriod camClock = ~camClock;
    end

    initial begin
        reset = 1'b1;                    // The DUT starts in reset.
        repeat (ResetCycles) @(posedge camClock);
        reset <= 1'b0;                   // Released on a rising edge like any other input.
    end

endmodule

`default_nettype wire

// ==== testbench/sobelEdgeDetectorTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sobelEdgeDetectorTb
    import sobelPkg::*, frameGeometryPkg::*;
();

    localparam int FrameRows     = 6;      // Rows per test frame.
    localparam int SettleLimit   = 200;    // Cycles allowed for the last words to appear.
    localparam int ResetLimit    = 20;     // Cycles allowed for reset to drop.
    localparam int FlatPattern   = 0;
    localparam int RandomPattern = 1;
    localparam int StripePattern = 2;

    logic      camClock;
    logic      reset;
    logic      pixelValid;
    logic      hsync;
    logic      vsync;
    pixelT     pixel;
    thresholdT threshold;
    logic      edgeWordValid;
    edgeWordT  edgeWord;

    pixelT       frame [FrameRows][LineWidth]; // Pixels of the current frame.
    edgeWordT    expectedWords [$];            // Model words still to come out.
    int          expectedDue [$];              // Falling edge at which each word is due.
    edgeWordT    modelWord;                    // Model bits of the current line.
    int          row = 0;                      // Row of the next pixel.
    int          column = 0;                   // Column of the next pixel.
    int          currentThreshold = 0;
    int          negCount = 0;                 // Falling edges seen so far.
    int          wordsChecked = 0;
    int          wordErrors = 0;
    int          timingErrors = 0;
    int          timeoutErrors = 0;
    logic [31:0] randomState;

    clockGen i_clockGen (
        .camClock (camClock),
        .reset    (reset)
    );

    sobelEdgeDetector i_sobelEdgeDetector (
        .camClock      (camClock),
        .reset         (reset),
        .pixelValid    (pixelValid),
        .hsync         (hsync),
        .vsync         (vsync),
        .pixel         (pixel),
        .threshold     (threshold),
        .edgeWordValid (edgeWordValid),
        .edgeWord      (edgeWord)
    );

    // Linear congruential generator for pixels and idle gaps.
    function automatic logic [31:0] nextRandom();
        randomState = randomState * 32'd1664525 + 32'd1013904223;
        return randomState;
    endfunction

    function automatic int px(input int r, input int c);
        return int'(frame[r][c]);
    endfunction

    // Edge bit of the window whose bottom-right pixel is (r, c).
    function automatic logic modelBit(input int r, input int c);
        int gx;
        int gy;
        int magnitude;
        if (r < 2 || c < 2) begin
            return 1'b0;                       // Window reaches outside the frame.
        end
        gx = px(r-2, c) + 2 * px(r-1, c) + px(r, c)
           - px(r-2, c-2) - 2 * px(r-1, c-2) - px(r, c-2);   // Right column minus left column.
        gy = px(r-2, c-2) + 2 * px(r-2, c-1) + px(r-2, c)
           - px(r, c-2) - 2 * px(r, c-1) - px(r, c);         // Top row minus bottom row.
        magnitude = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        return magnitude > currentThreshold;
    endfunction

    function automatic pixelT pixelFor(input int pattern, input int c);
        case (pattern)
            FlatPattern:   return 8'd100;
            StripePattern: return ((c / 4) % 2 == 1) ? 8'd200 : 8'd20; // Stripes four wide.
            default:       return pixelT'(nextRandom() >> 24);
        endcase
    endfunction

    // Vsync pulse that starts a new frame with a new threshold.
    task automatic startFrame(input int thr);
        @(posedge camClock);
        pixelValid <= 1'b0;
        vsync      <= 1'b1;
        threshold  <= thresholdT'(thr);
        @(posedge camClock);
        vsync <= 1'b0;
        currentThreshold = thr;
        row              = 0;
        column           = 0;
        modelWord        = '0;
    endtask

    task automatic sendPixel(input pixelT value, input int gap);
        int idle;
        for (idle = 0; idle < gap; idle++) begin
            @(posedge camClock);
            pixelValid <= 1'b0;                // Idle cycle between strobes.
        end
        @(posedge camClock);
        pixelValid <= 1'b1;
        pixel      <= value;
        frame[row][column] = value;
        modelWord = {modelWord[WordBits-2:0], modelBit(row, column)};
        column++;
        if (column % WordBits == 0) begin
            expectedWords.push_back(modelWord);
            expectedDue.push_back(negCount + 2); // Accepted at the next edge, out one cycle later.
        end
    endtask

    // Hsync closes the line and drops any partial word.
    task automatic endLine();
        @(posedge camClock);
        pixelValid <= 1'b0;
        hsync      <= 1'b1;
        @(posedge camClock);
        hsync <= 1'b0;
        row++;
        column    = 0;
        modelWord = '0;
    endtask

    task automatic sendLine(input int pattern, input int length, input logic withGaps);
        int    index;
        int    gap;
        pixelT value;
        for (index = 0; index < length; index++) begin
            gap   = withGaps ? int'((nextRandom() >> 16) % 4) : 0;
            value = pixelFor(pattern, column);
            sendPixel(value, gap);
        end
        endLine();
    endtask

    task automatic sendFrame(input int pattern, input int rows, input int thr,
                             input logic withGaps);
        int lineIndex;
        startFrame(thr);
        for (lineIndex = 0; lineIndex < rows; lineIndex++) begin
            sendLine(pattern, LineWidth, withGaps);
        end
    endtask

    // Outputs are sampled at the falling edge, half a cycle after they change.
    always @(negedge camClock) begin
        negCount++;
        if (!reset) begin
            if (edgeWordValid) begin
                pulseTiming: assert (expectedDue.size() > 0 && expectedDue[0] == negCount) else begin
                    timingErrors++;
                    $display("edgeWordValid pulsed when no word was due (falling edge %0d)",
                             negCount);
                end
                if (expectedWords.size() > 0) begin
                    wordValue: assert (edgeWord == expectedWords[0]) else begin
                        wordErrors++;
                        $display("FAILED edgeWord = %h, expected %h", edgeWord, expectedWords[0]);
                    end
                    expectedWords.pop_front();
                    expectedDue.pop_front();
                    wordsChecked++;
                end
            end else begin
                pulseMissing: assert (expectedDue.size() == 0 || expectedDue[0] > negCount) else begin
                    timingErrors++;
                    $display("edgeWordValid stayed low when a word was due (falling edge %0d)",
                             negCount);
                    expectedWords.pop_front(); // The missed word is not waited for again.
                    expectedDue.pop_front();
                end
            end
        end
    end

    initial begin
        int waitCycles;
        pixelValid  = 1'b0;
        pixel       = '0;
        hsync       = 1'b0;
        vsync       = 1'b0;
        threshold   = '0;
        modelWord   = '0;
        randomState = 32'hb0825f82;

        waitCycles = 0;
        while (reset !== 1'b0 && waitCycles < ResetLimit) begin
            @(posedge camClock);
            waitCycles++;
        end
        if (reset !== 1'b0) begin
            timeoutErrors++;
            $display("Timed out waiting for reset to be released");
        end

        repeat (5) @(posedge camClock);             // No word may appear while idle.
        sendFrame(FlatPattern, FrameRows, 0, 1'b0);
        sendFrame(RandomPattern, FrameRows, 400, 1'b0);
        sendFrame(StripePattern, FrameRows, 0, 1'b0);

        // Short line at the end of a frame, then a short first row before a full one.
        sendFrame(RandomPattern, 3, 400, 1'b0);
        sendLine(RandomPattern, 40, 1'b0);
        startFrame(400);
        sendLine(RandomPattern, 40, 1'b0);           // Its tail bits must not shift row 1.
        sendLine(RandomPattern, LineWidth, 1'b0);
        sendFrame(RandomPattern, 4, 400, 1'b0);

        sendFrame(RandomPattern, FrameRows, 300, 1'b1);

        waitCycles = 0;
        while (expectedWords.size() > 0 && waitCycles < SettleLimit) begin
            @(posedge camClock);
            waitCycles++;
        end
        if (expectedWords.size() > 0) begin
            timeoutErrors++;
            $display("Timed out waiting for %0d edge words", expectedWords.size());
        end

        $display("Words checked %0d, value errors %0d, timing errors %0d, timeouts %0d",
                 wordsChecked, wordErrors, timingErrors, timeoutErrors);
        if (wordErrors + timingErrors + timeoutErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/sobelPkg.sv
verilog/frameGeometryPkg.sv
verilog/scanSequencer.sv
verilog/windowLane.sv
verilog/edgePacker.sv
verilog/sobelEdgeDetector.sv
testbench/clockGen.sv
testbench/sobelEdgeDetectorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the Sobel edge detector testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module sobelEdgeDetectorTb \
    -Mdir "$buildDir" \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/VsobelEdgeDetectorTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST FAILED" "$logFile"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0
